//--- src/cam_pkg.sv
package cam_pkg;

    ////////////////////////////////////////
    // pixel format widths
    ////////////////////////////////////////
    localparam int BYTE_BITS  = 8;                           // sensor bus width
    localparam int CHAN_BITS  = 8;                           // output channel width
    localparam int RED_BITS   = 5;                           // rgb565 red field
    localparam int GREEN_BITS = 6;                           // rgb565 green field
    localparam int BLUE_BITS  = 5;                           // rgb565 blue field
    localparam int PIX_BITS   = RED_BITS + GREEN_BITS + BLUE_BITS; // 16 bits packed

    ////////////////////////////////////////
    // plain vector types
    ////////////////////////////////////////
    typedef logic [BYTE_BITS-1:0] byte_t;                    // one sensor byte
    typedef logic [PIX_BITS-1:0]  rgb565_t;                  // r[15:11] g[10:5] b[4:0]
    typedef logic [CHAN_BITS-1:0] chan_t;                    // one 8-bit colour

    ////////////////////////////////////////
    // grouped signals
    ////////////////////////////////////////
    typedef struct packed
    {
        chan_t red;                                          // bits 23:16
        chan_t green;                                        // bits 15:8
        chan_t blue;                                         // bits 7:0
    } rgb888_t;

    // sensor pins, 10 bits
    typedef struct packed
    {
        logic  vsync;                                        // frame sync from sensor
        logic  href;                                         // line valid
        byte_t data;                                         // byte stream
    } cam_in_t;

    // packer output, 18 bits
    typedef struct packed
    {
        logic    valid;                                      // one-cycle pixel strobe
        logic    vsync;                                      // delayed frame sync
        rgb565_t pixel;                                      // packed pixel
    } pix565_t;

    // video output, 26 bits
    typedef struct packed
    {
        logic    de;                                         // data enable
        logic    vs;                                         // vertical sync
        rgb888_t rgb;                                        // expanded colour
    } vid_out_t;

endpackage

//--- src/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////////////////////////
    // key counter types and limits
    ////////////////////////////////////////
    typedef logic [1:0] ctrl_cnt_t;                          // press count value

    localparam ctrl_cnt_t DIM_MAX     = 2'd2;                // dim levels 0..2
    localparam ctrl_cnt_t REVERSE_MAX = 2'd1;                // reverse off/on

    localparam int DEBOUNCE_CYCLES = 16;                     // stable samples to accept

    typedef logic [4:0] debounce_cnt_t;                      // counts up to 16

    ////////////////////////////////////////
    // debounce fsm
    ////////////////////////////////////////
    typedef enum logic [1:0]
    {
        KEY_UP,                                              // released, stable
        KEY_FALL_WAIT,                                       // going low, filtering
        KEY_DOWN,                                            // pressed, stable
        KEY_RISE_WAIT                                        // going high, filtering
    } key_state_e;

    // adjustment controls for the pixel path
    typedef struct packed
    {
        ctrl_cnt_t dim_level;                                // right shift amount
        logic      reverse;                                  // invert all channels
    } pixel_ctrl_t;

endpackage

//--- src/cam_byte_pack.sv
`timescale 1ns/1ns

module cam_byte_pack
(
    input  logic              core_clk,                      // pixel clock domain
    input  logic              rst_n_i,                       // sync, active low
    input  cam_pkg::cam_in_t  cam_i,                         // raw sensor pins
    output cam_pkg::pix565_t  pix_o                          // paired rgb565 pixels
);

    typedef enum logic
    {
        PACK_HIGH,                                           // expecting first byte
        PACK_LOW                                             // expecting second byte
    } pack_state_e;

    cam_pkg::cam_in_t cam_q;                                 // registered pins
    cam_pkg::byte_t   high_byte_q;                           // held first byte
    pack_state_e      state_q;                               // byte phase on the line

    ////////////////////////////////////////
    // input register
    ////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            cam_q <= '0;                                     // href/vsync low at start
        end
        else
        begin
            cam_q <= cam_i;                                  // all pins together in one cycle
        end
    end

    ////////////////////////////////////////
    // pairing fsm
    ////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= PACK_HIGH;
        end
        else if (!cam_q.href)
        begin
            state_q <= PACK_HIGH;                            // odd byte dropped and line restarts
        end
        else
        begin
            case (state_q)
                PACK_HIGH: state_q <= PACK_LOW;
                PACK_LOW:  state_q <= PACK_HIGH;
                default:   state_q <= PACK_HIGH;
            endcase
        end
    end

    // first byte of the pair
    always_ff @(posedge core_clk)
    begin
        if (cam_q.href && state_q == PACK_HIGH)
        begin
            high_byte_q <= cam_q.data;                       // high byte of rgb565
        end
    end

    ////////////////////////////////////////
    // pixel output
    ////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            pix_o <= '0;                                     // no strobe, zero pixel
        end
        else
        begin
            pix_o.vsync <= cam_q.vsync;                      // keeps step with data
            pix_o.valid <= cam_q.href && (state_q == PACK_LOW); // strobe on low byte
            if (cam_q.href && state_q == PACK_LOW)
            begin
                pix_o.pixel <= {high_byte_q, cam_q.data};    // high byte first
            end
        end
    end

endmodule

//--- src/key_ctl.sv
`timescale 1ns/1ns

module key_ctl
#(
    parameter ctrl_pkg::ctrl_cnt_t count_max = ctrl_pkg::DIM_MAX // last value before wrap
)
(
    input  logic                core_clk,
    input  logic                rst_n_i,                     // sync, active low
    input  logic                key_n_i,                     // raw key, low when pressed
    output ctrl_pkg::ctrl_cnt_t count_o                      // accepted press count
);

    localparam ctrl_pkg::debounce_cnt_t STABLE_LAST =
        ctrl_pkg::debounce_cnt_t'(ctrl_pkg::DEBOUNCE_CYCLES - 1);

    logic                    key_meta_q;                     // first sync stage
    logic                    key_sync_q;                     // second sync stage
    ctrl_pkg::key_state_e    state_q;
    ctrl_pkg::debounce_cnt_t stable_cnt_q;                   // stable sample count

    ////////////////////////////////////////
    // two-flop synchroniser
    ////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            key_meta_q <= 1'b1;                              // idle is released
            key_sync_q <= 1'b1;
        end
        else
        begin
            key_meta_q <= key_n_i;
            key_sync_q <= key_meta_q;
        end
    end

    ////////////////////////////////////////
    // debounce fsm and press counter
    ////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            state_q      <= ctrl_pkg::KEY_UP;
            stable_cnt_q <= '0;
            count_o      <= '0;
        end
        else
        begin
            case (state_q)
                ctrl_pkg::KEY_UP:
                begin
                    stable_cnt_q <= '0;
                    if (!key_sync_q)
                        state_q <= ctrl_pkg::KEY_FALL_WAIT;  // possible press
                end
                ctrl_pkg::KEY_FALL_WAIT:
                begin
                    if (key_sync_q)
                        state_q <= ctrl_pkg::KEY_UP;         // bounce, back off
                    else if (stable_cnt_q == STABLE_LAST)
                    begin
                        state_q <= ctrl_pkg::KEY_DOWN;       // press accepted
                        count_o <= (count_o == count_max) ? '0 : count_o + 2'd1; // wrap
                    end
                    else
                        stable_cnt_q <= stable_cnt_q + 5'd1;
                end
                ctrl_pkg::KEY_DOWN:
                begin
                    stable_cnt_q <= '0;
                    if (key_sync_q)
                        state_q <= ctrl_pkg::KEY_RISE_WAIT;  // possible release
                end
                ctrl_pkg::KEY_RISE_WAIT:
                begin
                    if (!key_sync_q)
                        state_q <= ctrl_pkg::KEY_DOWN;       // still held
                    else if (stable_cnt_q == STABLE_LAST)
                        state_q <= ctrl_pkg::KEY_UP;         // release accepted
                    else
                        stable_cnt_q <= stable_cnt_q + 5'd1;
                end
                default: state_q <= ctrl_pkg::KEY_UP;
            endcase
        end
    end

endmodule

//--- src/pixel_adjust.sv
`timescale 1ns/1ns

module pixel_adjust
(
    input  logic                  core_clk,
    input  logic                  rst_n_i,                   // sync, active low
    input  cam_pkg::pix565_t      pix_i,                     // strobed rgb565 pixels
    input  ctrl_pkg::pixel_ctrl_t ctrl_i,                    // dim level and reverse
    output cam_pkg::vid_out_t     vid_o                      // rgb888 video out
);

    // dim first, then optional inversion
    function automatic cam_pkg::chan_t adjust_chan
    (
        input cam_pkg::chan_t        chan,
        input ctrl_pkg::pixel_ctrl_t ctrl
    );
        cam_pkg::chan_t dimmed;
        dimmed = chan >> ctrl.dim_level;                     // 0, 1 or 2 bits down
        return dimmed ^ {cam_pkg::CHAN_BITS{ctrl.reverse}};  // bitwise invert when set
    endfunction

    cam_pkg::chan_t  red_exp;                                // zero-filled expansions
    cam_pkg::chan_t  green_exp;
    cam_pkg::chan_t  blue_exp;
    cam_pkg::rgb888_t rgb_adj;                               // transformed pixel

    ////////////////////////////////////////
    // rgb565 field split and expand
    ////////////////////////////////////////
    always_comb
    begin
        red_exp   = cam_pkg::chan_t'(pix_i.pixel[cam_pkg::PIX_BITS-1 -: cam_pkg::RED_BITS])
                    << (cam_pkg::CHAN_BITS - cam_pkg::RED_BITS);    // 3 low zeros
        green_exp = cam_pkg::chan_t'(pix_i.pixel[cam_pkg::BLUE_BITS +: cam_pkg::GREEN_BITS])
                    << (cam_pkg::CHAN_BITS - cam_pkg::GREEN_BITS);  // 2 low zeros
        blue_exp  = cam_pkg::chan_t'(pix_i.pixel[0 +: cam_pkg::BLUE_BITS])
                    << (cam_pkg::CHAN_BITS - cam_pkg::BLUE_BITS);   // 3 low zeros

        rgb_adj.red   = adjust_chan(red_exp, ctrl_i);
        rgb_adj.green = adjust_chan(green_exp, ctrl_i);
        rgb_adj.blue  = adjust_chan(blue_exp, ctrl_i);
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            vid_o <= '0;                                     // de/vs low, black pixel
        end
        else
        begin
            vid_o.de <= pix_i.valid;                         // follows the strobe
            vid_o.vs <= pix_i.vsync;                         // same delay as data
            if (pix_i.valid)
            begin
                vid_o.rgb <= rgb_adj;                        // hold last pixel otherwise
            end
        end
    end

endmodule

//--- src/cam_top.sv
`timescale 1ns/1ns

module cam_top
(
    input  logic              core_clk,                      // camera pixel clock
    input  logic              rst_n_i,                       // sync, active low
    input  cam_pkg::cam_in_t  cam_i,                         // sensor vsync/href/data
    input  logic              key_dim_n_i,                   // dim step key
    input  logic              key_reverse_n_i,               // colour reverse key
    output cam_pkg::vid_out_t vid_o                          // de, vs, rgb888
);

    ////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////
    cam_pkg::pix565_t      pix;                              // packer to adjust
    ctrl_pkg::ctrl_cnt_t   dim_cnt;                          // 0..2
    ctrl_pkg::ctrl_cnt_t   reverse_cnt;                      // 0..1
    ctrl_pkg::pixel_ctrl_t pix_ctrl;                         // combined controls

    assign pix_ctrl = '{dim_level: dim_cnt, reverse: reverse_cnt[0]}; // lsb toggles

    ////////////////////////////////////////
    // capture path
    ////////////////////////////////////////
    cam_byte_pack u_byte_pack
    (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .cam_i    (cam_i),                                   // raw pins
        .pix_o    (pix)                                      // 2 cycles later
    );

    pixel_adjust u_pixel_adjust
    (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .pix_i    (pix),
        .ctrl_i   (pix_ctrl),
        .vid_o    (vid_o)                                    // 1 more cycle
    );

    ////////////////////////////////////////
    // key controllers
    ////////////////////////////////////////
    key_ctl
    #(
        .count_max (ctrl_pkg::DIM_MAX)                       // 0, 1, 2, wrap
    )
    u_key_dim
    (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .key_n_i  (key_dim_n_i),
        .count_o  (dim_cnt)
    );

    key_ctl
    #(
        .count_max (ctrl_pkg::REVERSE_MAX)                   // toggles 0/1
    )
    u_key_reverse
    (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .key_n_i  (key_reverse_n_i),
        .count_o  (reverse_cnt)
    );

endmodule

//--- include/cam_tb_model.svh
`ifndef CAM_TB_MODEL_SVH
`define CAM_TB_MODEL_SVH

////////////////////////////////////////
// reference model
////////////////////////////////////////

// expected rgb888 for one rgb565 pixel
function automatic cam_pkg::rgb888_t expected_rgb
(
    input cam_pkg::rgb565_t    pix,
    input ctrl_pkg::ctrl_cnt_t dim,
    input logic                reverse
);
    cam_pkg::rgb888_t exp;
    exp.red   = {pix[15:11], 3'b000};                        // expand red
    exp.green = {pix[10:5], 2'b00};                          // expand green
    exp.blue  = {pix[4:0], 3'b000};                          // expand blue
    exp.red   = exp.red >> dim;                              // dim by shift
    exp.green = exp.green >> dim;
    exp.blue  = exp.blue >> dim;
    if (reverse)
    begin
        exp = ~exp;                                          // all 24 bits inverted
    end
    return exp;
endfunction

////////////////////////////////////////
// compare helpers
////////////////////////////////////////

// one output pixel against the model
task automatic check_rgb
(
    input  cam_pkg::rgb888_t got,
    input  cam_pkg::rgb888_t exp,
    input  int               index,
    inout  int               errors
);
    if (got !== exp)
    begin
        errors++;
        $display("[FAIL] vid_o.rgb pixel %0d got %06h expected %06h", index, got, exp);
    end
endtask

// totals such as pixel count and vs edges
task automatic check_count
(
    input  string what,
    input  int    got,
    input  int    exp,
    inout  int    errors
);
    if (got != exp)
    begin
        errors++;
        $display("[FAIL] %s got %0h expected %0h", what, got, exp);
    end
endtask

`endif

//--- verification/cam_top_tb.sv
`timescale 1ns/1ns

module cam_top_tb;

    ////////////////////////////////////////
    // stimulus shape
    ////////////////////////////////////////
    localparam int CLK_HALF      = 4;                        // 8 ns period
    localparam int RESET_CYCLES  = 4;
    localparam int VSYNC_CYCLES  = 3;                        // vsync pulse width
    localparam int FRAME_GAP     = 4;                        // idle after vsync
    localparam int LINE_GAP      = 6;                        // href low between lines
    localparam int NUM_LINES     = 4;
    localparam int NUM_FRAMES    = 6;
    localparam int NUM_PRESSES   = NUM_FRAMES - 1;           // one between each frame pair
    localparam int KEY_HOLD      = 40;                       // press and release length
    localparam int PIPE_LATENCY  = 3;                        // pins to vid_o
    localparam int LINE_LEN [NUM_LINES] = '{8, 7, 10, 5};    // odd lines drop a byte
    localparam bit PRESS_IS_DIM [NUM_PRESSES] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

    logic              core_clk;
    logic              rst_n_i;
    cam_pkg::cam_in_t  cam_i;
    logic              key_dim_n_i;
    logic              key_reverse_n_i;
    cam_pkg::vid_out_t vid_o;

    `include "cam_tb_model.svh"

    cam_pkg::rgb888_t    exp_q [$];                          // expected pixels in order
    ctrl_pkg::ctrl_cnt_t dim_model;                          // tracked dim level
    logic                reverse_model;                      // tracked reverse bit
    logic                frame_started;
    logic                vs_prev;
    int                  seed = 85238;
    int                  pix_seen;
    int                  vs_edges;
    int                  pix_errors;
    int                  count_errors;
    int                  other_errors;
    int                  cycle_cnt;
    int                  timeout_cycles;

    cam_top dut
    (
        .core_clk        (core_clk),
        .rst_n_i         (rst_n_i),
        .cam_i           (cam_i),
        .key_dim_n_i     (key_dim_n_i),
        .key_reverse_n_i (key_reverse_n_i),
        .vid_o           (vid_o)
    );

    initial
    begin
        core_clk = 1'b0;
        forever #CLK_HALF core_clk = ~core_clk;
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // whole run length in cycles
    function automatic int stim_cycles();
        int frame_len;
        frame_len = VSYNC_CYCLES + FRAME_GAP;
        for (int i = 0; i < NUM_LINES; i++)
            frame_len += LINE_LEN[i] + LINE_GAP;
        return RESET_CYCLES + NUM_FRAMES * frame_len + NUM_PRESSES * 2 * KEY_HOLD
               + PIPE_LATENCY + 1;
    endfunction

    // pixels a frame yields as floor of half each line
    function automatic int frame_pixels();
        int total;
        total = 0;
        for (int i = 0; i < NUM_LINES; i++)
            total += LINE_LEN[i] / 2;
        return total;
    endfunction

    task automatic drive_line(input int nbytes);
        cam_pkg::byte_t   data_b;
        cam_pkg::byte_t   high_b;
        cam_pkg::rgb565_t pix;
        high_b = '0;
        for (int i = 0; i < nbytes; i++)
        begin
            @(posedge core_clk);
            data_b = cam_pkg::byte_t'($random(seed));
            cam_i <= '{vsync: 1'b0, href: 1'b1, data: data_b};
            if (i % 2 == 0)
                high_b = data_b;                             // first byte is high
            else
            begin
                pix = {high_b, data_b};
                exp_q.push_back(expected_rgb(pix, dim_model, reverse_model));
            end
        end
        for (int i = 0; i < LINE_GAP; i++)
        begin
            @(posedge core_clk);
            cam_i <= '0;                                     // href low and bus idle
        end
    endtask

    task automatic drive_frame();
        frame_started = 1'b1;
        for (int i = 0; i < VSYNC_CYCLES; i++)
        begin
            @(posedge core_clk);
            cam_i <= '{vsync: 1'b1, href: 1'b0, data: 8'h00};
        end
        for (int i = 0; i < FRAME_GAP; i++)
        begin
            @(posedge core_clk);
            cam_i <= '0;
        end
        for (int l = 0; l < NUM_LINES; l++)
            drive_line(LINE_LEN[l]);
    endtask

    // hold low then high so the count settles within the hold
    task automatic press_key(input bit is_dim);
        @(posedge core_clk);
        if (is_dim)
            key_dim_n_i <= 1'b0;
        else
            key_reverse_n_i <= 1'b0;
        repeat (KEY_HOLD) @(posedge core_clk);
        if (is_dim)
            key_dim_n_i <= 1'b1;
        else
            key_reverse_n_i <= 1'b1;
        repeat (KEY_HOLD - 1) @(posedge core_clk);
        if (is_dim)
            dim_model = (dim_model == ctrl_pkg::DIM_MAX) ? 2'd0 : dim_model + 2'd1; // wrap
        else
            reverse_model = ~reverse_model;                  // toggles
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        rst_n_i         = 1'b0;
        cam_i           = '0;
        key_dim_n_i     = 1'b1;                              // keys released
        key_reverse_n_i = 1'b1;
        dim_model       = '0;
        reverse_model   = 1'b0;
        frame_started   = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge core_clk);                      // idle outputs checked here
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            drive_frame();
            if (f < NUM_PRESSES)
                press_key(PRESS_IS_DIM[f]);
        end
        while (exp_q.size() != 0)
            @(posedge core_clk);
        repeat (PIPE_LATENCY) @(posedge core_clk);           // catch any stray strobe
        check_count("vid_o.de pixel count", pix_seen, NUM_FRAMES * frame_pixels(),
                    count_errors);
        check_count("vid_o.vs rising edges", vs_edges, NUM_FRAMES, count_errors);
        $display("errors: pixel %0d, count %0d, other %0d", pix_errors, count_errors,
                 other_errors);
        if (pix_errors + count_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////
    initial
    begin
        pix_seen     = 0;
        vs_edges     = 0;
        pix_errors   = 0;
        count_errors = 0;
        other_errors = 0;
        vs_prev      = 1'b0;
    end

    always @(negedge core_clk)                               // outputs settled mid-cycle
    begin
        if (rst_n_i && !frame_started && vid_o !== '0)
        begin
            other_errors++;
            $display("[FAIL] vid_o = %07h before first frame, expected 0000000", vid_o);
        end
        if (vid_o.vs && !vs_prev)
            vs_edges++;
        vs_prev = vid_o.vs;
        if (vid_o.de)
        begin
            if (exp_q.size() == 0)
            begin
                other_errors++;
                $display("output pixel %0d arrived with no expected pixel pending", pix_seen);
            end
            else
                check_rgb(vid_o.rgb, exp_q.pop_front(), pix_seen, pix_errors);
            pix_seen++;
        end
    end

    ////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////
    initial
    begin
        cycle_cnt      = 0;
        timeout_cycles = 10 * stim_cycles();                 // generous margin
        while (cycle_cnt < timeout_cycles)
        begin
            @(posedge core_clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_cnt);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
src/cam_pkg.sv
src/ctrl_pkg.sv
src/cam_byte_pack.sv
src/key_ctl.sv
src/pixel_adjust.sv
src/cam_top.sv
verification/cam_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the camera capture testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module cam_top_tb -f tb.f -o cam_sim || exit 1
sim_out=$(./obj_dir/cam_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "Result: PASSED" && exit 0 || exit 1
